/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_frame_buffer
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^Everything OK$$' $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/burst_queue.sv */
`timescale 1ns/1ps

module burst_queue import fb_pkg::*; #(
    parameter type payload_t = logic [BURST_W-1:0], // entry type
    parameter int  DEPTH     = 4,                   // entries
    parameter int  AF_LEVEL  = 3,                   // almost-full threshold
    parameter int  PTR_W     = $clog2(DEPTH),
    parameter int  CNT_W     = $clog2(DEPTH + 1)
) (
    input  wire                 clk,
    input  wire                 i_rst_n,

    input  wire                 i_valid,       // write side
    input  payload_t            i_data,
    output logic                o_ready,

    output logic                o_valid,       // read side
    output payload_t            o_data,
    input  wire                 i_ready,

    output logic                o_almost_full,
    output logic [CNT_W-1:0]    o_count        // occupancy
);

    payload_t           mem [DEPTH];  // storage, no reset
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1; // wrap for any depth
    endfunction

    assign o_ready       = (o_count != CNT_W'(DEPTH));
    assign o_valid       = (o_count != '0);
    assign o_almost_full = (o_count >= CNT_W'(AF_LEVEL));
    assign push          = i_valid && o_ready;
    assign pop           = o_valid && i_ready;
    assign o_data        = mem[rd_ptr];  // head visible the cycle after the write

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            o_count <= o_count + CNT_W'(push) - CNT_W'(pop); // push and pop may coincide
        end
    end

endmodule

/* logic/fb_pkg.sv */
package fb_pkg;

    // frame geometry, kept small for simulation
    localparam int H_ACTIVE         = 64;                   // pixels per line
    localparam int V_ACTIVE         = 8;                    // lines per frame
    localparam int PIX_W            = 16;                   // rgb565 pixel

    // burst sizing, one burst is a full 128-bit memory word
    localparam int PIX_PER_BURST    = 8;                    // pixels packed per burst
    localparam int BURST_W          = PIX_W * PIX_PER_BURST; // 128 bits
    localparam int BURSTS_PER_FRAME = (H_ACTIVE * V_ACTIVE) / PIX_PER_BURST; // 64
    localparam int ADDR_W           = 6;                    // burst address bits
    localparam int LANE_W           = $clog2(PIX_PER_BURST); // lane index bits

    localparam logic [ADDR_W-1:0] LAST_BURST = ADDR_W'(BURSTS_PER_FRAME - 1); // burst 63
    localparam logic [LANE_W-1:0] LAST_LANE  = LANE_W'(PIX_PER_BURST - 1);    // lane 7

    // display/producer counter widths
    localparam int HC_W             = 7;                    // h count 0..63
    localparam int VC_W             = 4;                    // v count 0..7

    // queue sizing
    localparam int WQ_DEPTH         = 4;                    // write queue entries
    localparam int RQ_DEPTH         = 4;                    // read queue entries
    localparam int RQ_AF_LEVEL      = 3;                    // prefetch stops at this level
    localparam int RQ_CNT_W         = $clog2(RQ_DEPTH + 1); // occupancy 0..RQ_DEPTH

    // memory model timing
    localparam int MEM_LATENCY      = 2;                    // accepted read to ack
    localparam int LAT_W            = $clog2(MEM_LATENCY + 1);

    // shown whenever the unstacker has nothing to give
    localparam logic [PIX_W-1:0] FALLBACK_PIX = 16'h2277;

endpackage

/* logic/frame_buffer_top.sv */
`timescale 1ns/1ps

module frame_buffer_top import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // pixel producer
    input  wire                 i_rtx_valid,
    input  wire [PIX_W-1:0]     i_rtx_pixel,
    input  wire [HC_W-1:0]      i_rtx_h_count,
    input  wire [VC_W-1:0]      i_rtx_v_count,
    output logic                o_rtx_ready,

    // display scan-out
    input  wire                 i_draw_active,
    input  wire [HC_W-1:0]      i_h_count,
    input  wire [VC_W-1:0]      i_v_count,
    output logic [PIX_W-1:0]    o_pixel
);

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [BURST_W-1:0] burst;
    } wq_entry_t;  // write queue entry

    typedef struct packed {
        logic [BURST_W-1:0] burst;
        logic               last;
    } rq_entry_t;  // read queue entry

    logic                st_valid;        // stacker to write queue
    logic                st_ready;
    logic [BURST_W-1:0]  st_burst;
    logic [ADDR_W-1:0]   st_addr;

    logic                wq_valid;        // write queue to generator
    logic                wq_ready;
    wq_entry_t           wq_data;

    logic                rq_in_valid;     // generator to read queue
    logic [BURST_W-1:0]  rq_in_burst;
    logic                rq_in_last;
    logic                rq_almost_full;
    logic [RQ_CNT_W-1:0] rq_count;

    logic                rq_valid;        // read queue to unstacker
    logic                rq_ready;
    rq_entry_t           rq_data;

    logic                mem_en;          // request bus
    logic                mem_we;
    logic [ADDR_W-1:0]   mem_addr;
    logic [BURST_W-1:0]  mem_wdata;
    logic                mem_stall;
    logic                mem_ack;
    logic [BURST_W-1:0]  mem_rdata;

    pixel_stacker u_stacker (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_valid(i_rtx_valid), .i_pixel(i_rtx_pixel),
        .i_h_count(i_rtx_h_count), .i_v_count(i_rtx_v_count), .o_ready(o_rtx_ready),
        .o_valid(st_valid), .o_burst(st_burst), .o_addr(st_addr), .i_ready(st_ready)
    );

    burst_queue #(.payload_t(wq_entry_t), .DEPTH(WQ_DEPTH), .AF_LEVEL(WQ_DEPTH)) u_wq (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_valid(st_valid), .i_data({st_addr, st_burst}), .o_ready(st_ready),
        .o_valid(wq_valid), .o_data(wq_data), .i_ready(wq_ready),
        .o_almost_full(), .o_count()
    );

    traffic_generator u_tgen (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_wq_valid(wq_valid), .i_wq_addr(wq_data.addr), .i_wq_burst(wq_data.burst),
        .o_wq_ready(wq_ready),
        .o_rq_valid(rq_in_valid), .o_rq_burst(rq_in_burst), .o_rq_last(rq_in_last),
        .i_rq_almost_full(rq_almost_full), .i_rq_count(rq_count),
        .o_mem_en(mem_en), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .i_mem_stall(mem_stall), .i_mem_ack(mem_ack),
        .i_mem_rdata(mem_rdata)
    );

    frame_memory u_mem (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_en(mem_en), .i_we(mem_we), .i_addr(mem_addr), .i_wdata(mem_wdata),
        .o_stall(mem_stall), .o_ack(mem_ack), .o_rdata(mem_rdata)
    );

    burst_queue #(.payload_t(rq_entry_t), .DEPTH(RQ_DEPTH), .AF_LEVEL(RQ_AF_LEVEL)) u_rq (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_valid(rq_in_valid), .i_data({rq_in_burst, rq_in_last}), .o_ready(),
        .o_valid(rq_valid), .o_data(rq_data), .i_ready(rq_ready),
        .o_almost_full(rq_almost_full), .o_count(rq_count)
    );

    scanout_unstacker u_unstacker (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_valid(rq_valid), .i_burst(rq_data.burst), .i_last(rq_data.last),
        .o_ready(rq_ready),
        .i_draw_active(i_draw_active), .i_h_count(i_h_count), .i_v_count(i_v_count),
        .o_pixel(o_pixel)
    );

endmodule

/* logic/frame_memory.sv */
`timescale 1ns/1ps

module frame_memory import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // request side
    input  wire                 i_en,
    input  wire                 i_we,
    input  wire [ADDR_W-1:0]    i_addr,
    input  wire [BURST_W-1:0]   i_wdata,

    // response side
    output logic                o_stall,
    output logic                o_ack,
    output logic [BURST_W-1:0]  o_rdata
);

    logic [BURST_W-1:0] mem [BURSTS_PER_FRAME];  // one frame of bursts
    logic               busy;                    // request in flight
    logic [LAT_W-1:0]   lat_cnt;                 // cycles left until ack
    logic               take;

    assign take    = i_en && !busy;
    assign o_stall = busy;                          // high through the ack cycle
    assign o_ack   = busy && (lat_cnt == LAT_W'(1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (take) begin
            busy    <= 1'b1;
            lat_cnt <= i_we ? LAT_W'(1) : LAT_W'(MEM_LATENCY); // writes ack next cycle
        end else if (busy) begin
            if (o_ack) busy <= 1'b0;
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // array access happens at take, read data waits in o_rdata for the ack
    always_ff @(posedge clk) begin
        if (take && i_we) begin
            mem[i_addr] <= i_wdata;
        end
        if (take && !i_we) begin
            o_rdata <= mem[i_addr];
        end
    end

endmodule

/* logic/pixel_stacker.sv */
`timescale 1ns/1ps

module pixel_stacker import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // producer side, valid/ready
    input  wire                 i_valid,
    input  wire [PIX_W-1:0]     i_pixel,
    input  wire [HC_W-1:0]      i_h_count,
    input  wire [VC_W-1:0]      i_v_count,
    output logic                o_ready,

    // burst side toward the write queue
    output logic                o_valid,
    output logic [BURST_W-1:0]  o_burst,
    output logic [ADDR_W-1:0]   o_addr,
    input  wire                 i_ready
);

    logic [LANE_W-1:0] lane;       // lane picked by the low bits of h count
    logic              take;       // pixel handshake
    logic              last_lane;  // pixel closes the burst

    assign lane      = i_h_count[LANE_W-1:0];
    assign take      = i_valid && o_ready;
    assign last_lane = take && (lane == LAST_LANE);

    // payload, filled lane by lane, pixel 0 lands in the lsbs
    always_ff @(posedge clk) begin
        if (take) begin
            o_burst[lane*PIX_W +: PIX_W] <= i_pixel;
        end
        if (last_lane) begin
            o_addr <= ADDR_W'(i_v_count * (H_ACTIVE / PIX_PER_BURST)
                              + (i_h_count >> LANE_W)); // v*8 + h/8
        end
    end

    // handshake control; ready is registered so it stays low through reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_ready <= 1'b0;
        end else if (o_valid) begin
            if (i_ready) begin             // queue took the burst
                o_valid <= 1'b0;
                o_ready <= 1'b1;
            end
        end else if (last_lane) begin      // burst complete, hold it
            o_valid <= 1'b1;
            o_ready <= 1'b0;
        end else begin
            o_ready <= 1'b1;               // collecting
        end
    end

endmodule

/* logic/scanout_unstacker.sv */
`timescale 1ns/1ps

module scanout_unstacker import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // bursts from the read queue
    input  wire                 i_valid,
    input  wire [BURST_W-1:0]   i_burst,
    input  wire                 i_last,
    output logic                o_ready,

    // display timing and pixel out
    input  wire                 i_draw_active,
    input  wire [HC_W-1:0]      i_h_count,
    input  wire [VC_W-1:0]      i_v_count,
    output logic [PIX_W-1:0]    o_pixel
);

    logic [BURST_W-1:0] burst_q;   // burst being drawn
    logic               last_q;    // burst 63 of the frame
    logic               full_q;    // burst_q holds pixels
    logic [LANE_W-1:0]  lane_q;    // next pixel to release
    logic               pix_last;  // frame's final pixel
    logic               pix_ready; // display takes a pixel this cycle
    logic               at_end;    // counts sit on the last position

    assign at_end    = (i_h_count == HC_W'(H_ACTIVE - 1)) && (i_v_count == VC_W'(V_ACTIVE - 1));
    assign pix_last  = last_q && (lane_q == LAST_LANE);
    assign pix_ready = pix_last ? (i_draw_active && at_end) : i_draw_active; // hold tlast

    // load when empty, or while lane 7 is going out so lines have no gap
    assign o_ready = !full_q || (pix_ready && lane_q == LAST_LANE);

    assign o_pixel = full_q ? burst_q[lane_q*PIX_W +: PIX_W] : FALLBACK_PIX;

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            burst_q <= i_burst;
            last_q  <= i_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            full_q <= 1'b0;
            lane_q <= '0;
        end else if (i_valid && o_ready) begin
            full_q <= 1'b1;
            lane_q <= '0;                     // lsb pixel first
        end else if (full_q && pix_ready) begin
            if (lane_q == LAST_LANE) full_q <= 1'b0;
            lane_q <= lane_q + 1'b1;
        end
    end

endmodule

/* logic/traffic_generator.sv */
`timescale 1ns/1ps

module traffic_generator import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,

    // write queue head
    input  wire                 i_wq_valid,
    input  wire [ADDR_W-1:0]    i_wq_addr,
    input  wire [BURST_W-1:0]   i_wq_burst,
    output logic                o_wq_ready,

    // read queue push side
    output logic                o_rq_valid,
    output logic [BURST_W-1:0]  o_rq_burst,
    output logic                o_rq_last,
    input  wire                 i_rq_almost_full,
    input  wire [RQ_CNT_W-1:0]  i_rq_count,

    // memory request bus, stall/ack
    output logic                o_mem_en,
    output logic                o_mem_we,
    output logic [ADDR_W-1:0]   o_mem_addr,
    output logic [BURST_W-1:0]  o_mem_wdata,
    input  wire                 i_mem_stall,
    input  wire                 i_mem_ack,
    input  wire [BURST_W-1:0]   i_mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,  // pick the next request
        ST_REQ,   // request on the bus until taken
        ST_WAIT   // one request outstanding, wait for ack
    } state_t;

    state_t              state;
    logic [ADDR_W-1:0]   rd_addr;      // raster prefetch pointer, wraps at 63
    logic                frame_valid;  // one full frame stored
    logic [RQ_CNT_W-1:0] rq_free;      // free read queue slots
    logic                rd_ok;        // prefetch allowed this cycle

    assign rq_free = RQ_CNT_W'(RQ_DEPTH) - i_rq_count;
    assign rd_ok   = frame_valid && !i_rq_almost_full && (rq_free != '0);

    assign o_wq_ready = (state == ST_IDLE);  // pops the head when a write is chosen
    assign o_mem_en   = (state == ST_REQ);

    // read data goes straight into the read queue on its ack
    assign o_rq_valid = (state == ST_WAIT) && i_mem_ack && !o_mem_we;
    assign o_rq_burst = i_mem_rdata;
    assign o_rq_last  = (rd_addr == LAST_BURST);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            o_mem_we    <= 1'b0;
            rd_addr     <= '0;
            frame_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_wq_valid) begin          // writes always win
                        o_mem_we <= 1'b1;
                        state    <= ST_REQ;
                    end else if (rd_ok) begin
                        o_mem_we <= 1'b0;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (!i_mem_stall) state <= ST_WAIT;  // taken this cycle
                end
                ST_WAIT: begin
                    if (i_mem_ack) begin
                        state <= ST_IDLE;
                        if (o_mem_we && o_mem_addr == LAST_BURST) begin
                            frame_valid <= 1'b1;   // burst 63 written, scan-out may start
                        end
                        if (!o_mem_we) begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload, latched when leaving idle and held until taken
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (i_wq_valid) begin
                o_mem_addr  <= i_wq_addr;
                o_mem_wdata <= i_wq_burst;
            end else begin
                o_mem_addr  <= rd_addr;   // wdata is don't care for a read
            end
        end
    end

endmodule

/* src.f */
logic/fb_pkg.sv
logic/pixel_stacker.sv
logic/burst_queue.sv
logic/traffic_generator.sv
logic/frame_memory.sv
logic/scanout_unstacker.sv
logic/frame_buffer_top.sv
test/fb_monitor.sv
test/fb_checker.sv
test/tb_frame_buffer.sv

/* test/fb_checker.sv */
`timescale 1ns/1ps

module fb_checker import fb_pkg::*; (
    input  wire                 clk,
    input  wire                 i_rst_n,
    input  wire                 i_mem_we,
    input  wire [ADDR_W-1:0]    i_mem_addr,
    input  wire [BURST_W-1:0]   i_mem_wdata,
    input  wire                 i_mem_stall,
    input  wire                 i_rq_push,
    input  wire [RQ_CNT_W-1:0]  i_rq_count,
    input  wire                 i_rtx_ready
);

    int   fail_count = 0;
    logic in_reset   = 1'b0;   // reset seen at the previous edge

    // request fields hold while the memory is busy with it
    req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_stall |-> ($stable(i_mem_we) && $stable(i_mem_addr)
            && $stable(i_mem_wdata)))
        else begin
            fail_count++;
            $error("memory request changed while stalled");
        end

    rq_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rq_push |-> (i_rq_count != RQ_CNT_W'(RQ_DEPTH)))
        else begin
            fail_count++;
            $error("read queue pushed while full");
        end

    ready_low_in_reset: assert property (@(posedge clk)
        (in_reset && !i_rst_n) |-> !i_rtx_ready)
        else begin
            fail_count++;
            $error("o_rtx_ready high during reset");
        end

    always @(posedge clk) in_reset <= !i_rst_n;

endmodule

bind frame_buffer_top fb_checker u_checker (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_mem_we(mem_we), .i_mem_addr(mem_addr),
    .i_mem_wdata(mem_wdata), .i_mem_stall(mem_stall),
    .i_rq_push(rq_in_valid), .i_rq_count(rq_count),
    .i_rtx_ready(o_rtx_ready)
);

/* test/fb_monitor.sv */
`timescale 1ns/1ps

module fb_monitor import fb_pkg::*; (
    input  wire              clk,
    input  wire              i_rst_n,

    // display side of the DUT
    input  wire              i_draw_active,
    input  wire [HC_W-1:0]   i_h_count,
    input  wire [VC_W-1:0]   i_v_count,
    input  wire [PIX_W-1:0]  i_pixel,
    input  wire              i_rtx_ready,

    // what the testbench expects right now
    input  wire              i_check_en,
    input  wire              i_expect_fallback,
    input  wire [PIX_W-1:0]  i_base,

    output int               o_pix_errors,
    output int               o_reset_errors,
    output int               o_checked
);

    int               pix_errors   = 0;
    int               reset_errors = 0;
    int               checked      = 0;
    logic [PIX_W-1:0] expected;

    assign o_pix_errors   = pix_errors;
    assign o_reset_errors = reset_errors;
    assign o_checked      = checked;

    // sample mid-cycle, outputs settle after the edge and inputs after +1 ns
    always @(negedge clk) begin
        if (!i_rst_n) begin
            if (i_rtx_ready !== 1'b0) begin
                reset_errors++;
                $display("[ERROR] o_rtx_ready during reset: got %h expected 0", i_rtx_ready);
            end
            if (i_pixel !== FALLBACK_PIX) begin
                reset_errors++;
                $display("[ERROR] o_pixel during reset: got %h expected %h",
                         i_pixel, FALLBACK_PIX);
            end
        end else if (i_check_en && i_draw_active) begin
            expected = i_expect_fallback ? FALLBACK_PIX
                     : PIX_W'(int'(i_base) + int'(i_v_count) * H_ACTIVE + int'(i_h_count));
            checked++;
            if (i_pixel !== expected) begin
                pix_errors++;
                $display("[ERROR] o_pixel at h %h v %h: got %h expected %h",
                         i_h_count, i_v_count, i_pixel, expected);
            end
        end
    end

endmodule

/* test/tb_frame_buffer.sv */
`timescale 1ns/1ps

module tb_frame_buffer import fb_pkg::*; ();

    localparam int FRAME_PIX = H_ACTIVE * V_ACTIVE;                   // 512 pixels
    localparam int N_ROWS    = 4;
    localparam int LIMIT     = N_ROWS * (FRAME_PIX + 3 * FRAME_PIX) * 4 + 2000;
    localparam int CHECKS    = FRAME_PIX + N_ROWS * FRAME_PIX;        // fallback scan + rows

    typedef struct {
        logic [PIX_W-1:0] base;       // pixel value at h 0, v 0
        bit               prod_gaps;  // producer drops valid at random
        bit               disp_gaps;  // display drops draw_active at random
        int               scans;      // last one is checked
    } row_t;

    row_t              rows [N_ROWS];
    logic              clk;
    logic              i_rst_n;
    logic              i_rtx_valid;
    logic [PIX_W-1:0]  i_rtx_pixel;
    logic [HC_W-1:0]   i_rtx_h_count;
    logic [VC_W-1:0]   i_rtx_v_count;
    logic              o_rtx_ready;
    logic              i_draw_active;
    logic [HC_W-1:0]   i_h_count;
    logic [VC_W-1:0]   i_v_count;
    logic [PIX_W-1:0]  o_pixel;
    logic [PIX_W-1:0]  cur_base;
    logic              check_en;
    logic              expect_fallback;
    logic [31:0]       lfsr_state = 32'd84815;
    int                pix_errors;
    int                reset_errors;
    int                n_checked;
    int                assert_errors;
    int                cycles = 0;

    frame_buffer_top DUT (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_rtx_valid(i_rtx_valid), .i_rtx_pixel(i_rtx_pixel),
        .i_rtx_h_count(i_rtx_h_count), .i_rtx_v_count(i_rtx_v_count),
        .o_rtx_ready(o_rtx_ready),
        .i_draw_active(i_draw_active), .i_h_count(i_h_count), .i_v_count(i_v_count),
        .o_pixel(o_pixel)
    );

    fb_monitor u_monitor (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_draw_active(i_draw_active), .i_h_count(i_h_count), .i_v_count(i_v_count),
        .i_pixel(o_pixel), .i_rtx_ready(o_rtx_ready),
        .i_check_en(check_en), .i_expect_fallback(expect_fallback), .i_base(cur_base),
        .o_pix_errors(pix_errors), .o_reset_errors(reset_errors), .o_checked(n_checked)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;     // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: run did not complete within %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bit(output bit b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                        // drive just after the edge
    endtask

    task automatic send_pixel(input int h, input int v, input logic [PIX_W-1:0] base,
                              input bit gaps);
        bit idle;
        bit taken;
        idle  = 1'b0;
        taken = 1'b0;
        if (gaps) random_bit(idle);
        while (idle) begin
            i_rtx_valid = 1'b0;
            next_cycle();
            random_bit(idle);
        end
        i_rtx_valid   = 1'b1;
        i_rtx_pixel   = PIX_W'(int'(base) + v * H_ACTIVE + h);
        i_rtx_h_count = HC_W'(h);
        i_rtx_v_count = VC_W'(v);
        while (!taken) begin
            taken = o_rtx_ready;   // registered, steady until the next edge
            next_cycle();
        end
    endtask

    task automatic write_frame(input logic [PIX_W-1:0] base, input bit gaps);
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                send_pixel(h, v, base, gaps);
            end
        end
        i_rtx_valid = 1'b0;
        repeat (200) next_cycle(); // let the queue drain into memory
    endtask

    task automatic scan_frame(input bit gaps);
        bit hold;
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                hold      = 1'b0;
                i_h_count = HC_W'(h);
                i_v_count = VC_W'(v);
                if (gaps) random_bit(hold);
                while (hold) begin
                    i_draw_active = 1'b0;
                    next_cycle();
                    random_bit(hold);
                end
                i_draw_active = 1'b1;   // counts advance only on active cycles
                next_cycle();
            end
        end
        i_draw_active = 1'b0;
    endtask

    initial begin
        rows[0] = '{16'h0000, 1'b0, 1'b0, 2};
        rows[1] = '{16'h1234, 1'b1, 1'b0, 2};
        rows[2] = '{16'hA5C0, 1'b0, 1'b1, 2};
        rows[3] = '{16'hFF00, 1'b1, 1'b1, 2};  // values wrap past 16'hffff
        i_rst_n         = 1'b0;
        i_rtx_valid     = 1'b0;
        i_rtx_pixel     = '0;
        i_rtx_h_count   = '0;
        i_rtx_v_count   = '0;
        i_draw_active   = 1'b0;
        i_h_count       = '0;
        i_v_count       = '0;
        cur_base        = '0;
        check_en        = 1'b0;
        expect_fallback = 1'b0;
        repeat (10) next_cycle();
        i_rst_n = 1'b1;

        expect_fallback = 1'b1;    // nothing stored yet
        check_en        = 1'b1;
        scan_frame(1'b0);
        check_en        = 1'b0;
        expect_fallback = 1'b0;

        foreach (rows[r]) begin
            cur_base = rows[r].base;
            write_frame(rows[r].base, rows[r].prod_gaps);
            for (int s = 0; s < rows[r].scans; s++) begin
                check_en = (s == rows[r].scans - 1);  // earlier scans may show the old frame
                scan_frame(rows[r].disp_gaps);
            end
            check_en = 1'b0;
        end

        repeat (4) next_cycle();
        assert_errors = DUT.u_checker.fail_count;
        if (n_checked != CHECKS) begin
            $display("only %0d of %0d display pixels were checked", n_checked, CHECKS);
        end
        $display("errors: pixel %0d, reset %0d, assertion %0d; pixels checked %0d",
                 pix_errors, reset_errors, assert_errors, n_checked);
        if (pix_errors == 0 && reset_errors == 0 && assert_errors == 0
            && n_checked == CHECKS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
